/* hw/uopDecode_macros.svh */
// ==============================
// Width and field positions of a micro-op, shared by the decode package
// and the classifiers. Include it wherever a field is sliced out of instr
// ==============================

`ifndef UOP_DECODE_MACROS_SVH
`define UOP_DECODE_MACROS_SVH

// Full width of one micro-op as it leaves the front end
`define UOP_WIDTH 32

// Major opcode field, the low seven bits
`define OPC_LSB 0
`define OPC_MSB 6

// Function field, used by the FLT family to pick the operation
`define FUNC_LSB 22
`define FUNC_MSB 26

// The bits between the opcode and the function field hold register numbers,
// the bits above the function field an immediate. Decode never looks at them

`endif

/* hw/uopDecodePkg.sv */
// ==============================
// Types and encodings for micro-op decode. Import it in a module body,
// or use scoped names in a port list
// ==============================

`default_nettype none

package uopDecodePkg;

`include "uopDecode_macros.svh"

	// ==============================
	// Vector types
	// ==============================

	// One whole micro-op
	typedef logic [`UOP_WIDTH-1:0] microOpT;
	// Major opcode, sliced from the low end of the micro-op
	typedef logic [`OPC_MSB-`OPC_LSB:0] opcodeT;
	// Function code, only meaningful for some opcode groups
	typedef logic [`FUNC_MSB-`FUNC_LSB:0] funcT;

	// ==============================
	// Major opcodes
	// ==============================

	// Bit-field extract and insert
	localparam opcodeT OP_BFLD = 7'h01;

	// Three-register integer ops, by element size
	localparam opcodeT OP_R3B = 7'h02;
	localparam opcodeT OP_R3W = 7'h03;
	localparam opcodeT OP_R3T = 7'h04;
	localparam opcodeT OP_R3O = 7'h05;
	localparam opcodeT OP_R3P = 7'h06;

	// Floating-point ops by precision; func selects the operation
	localparam opcodeT OP_FLTH = 7'h08;
	localparam opcodeT OP_FLTS = 7'h09;
	localparam opcodeT OP_FLTD = 7'h0A;
	localparam opcodeT OP_FLTQ = 7'h0B;
	localparam opcodeT OP_FLTP = 7'h0C;

	// Bounds check and the immediate ALU group
	localparam opcodeT OP_CHK = 7'h10;
	localparam opcodeT OP_ADDI = 7'h11;
	localparam opcodeT OP_SUBFI = 7'h12;
	localparam opcodeT OP_CMPI = 7'h13;
	localparam opcodeT OP_CMPUI = 7'h14;
	localparam opcodeT OP_ANDI = 7'h15;
	localparam opcodeT OP_ORI = 7'h16;
	localparam opcodeT OP_XORI = 7'h17;

	// Shifts, control registers, moves and address generation
	localparam opcodeT OP_SHIFT = 7'h18;
	localparam opcodeT OP_CSR = 7'h19;
	localparam opcodeT OP_MOVMR = 7'h1A;
	localparam opcodeT OP_LOADA = 7'h1B;

	// Housekeeping ops, all handled by the simple unit
	localparam opcodeT OP_NOP = 7'h20;
	localparam opcodeT OP_PUSH = 7'h21;
	localparam opcodeT OP_POP = 7'h22;
	localparam opcodeT OP_FENCE = 7'h23;

	// Memory access and cache control
	localparam opcodeT OP_LOAD = 7'h28;
	localparam opcodeT OP_STORE = 7'h29;
	localparam opcodeT OP_CACHE = 7'h2A;

	// Flow control
	localparam opcodeT OP_BCC = 7'h30;
	localparam opcodeT OP_JMP = 7'h31;
	localparam opcodeT OP_JSR = 7'h32;
	localparam opcodeT OP_RET = 7'h33;

	// ==============================
	// FLT function codes
	// ==============================

	localparam funcT FLT_ADD = 5'h00;
	localparam funcT FLT_MUL = 5'h01;
	localparam funcT FLT_DIV = 5'h02;
	localparam funcT FLT_SQRT = 5'h03;
	// The next three need only sign and compare logic
	localparam funcT FLT_CMP = 5'h04;
	localparam funcT FLT_ABS = 5'h05;
	localparam funcT FLT_NEG = 5'h06;
	localparam funcT FLT_CVT = 5'h07;

endpackage

`default_nettype wire

/* hw/decodeSau.sv */
// ==============================
// Classifier for the simple arithmetic unit. Purely combinational,
// sau follows instr in the same cycle
// ==============================

`timescale 1ns/100ps
`default_nettype none

`include "uopDecode_macros.svh"

module decodeSau
(
	input uopDecodePkg::microOpT instr,
	output logic sau
);

	import uopDecodePkg::*;

	// Returns one for every micro-op the SAU executes
	function automatic logic isSau(input microOpT ir);
		opcodeT opc;
		funcT fn;
		opc = ir[`OPC_MSB:`OPC_LSB];
		fn = ir[`FUNC_MSB:`FUNC_LSB];
		case (opc)
			OP_BFLD:
				isSau = 1'b1;
			// Integer register-register ops of every size
			OP_R3B, OP_R3W, OP_R3T, OP_R3O, OP_R3P:
				isSau = 1'b1;
			// Only the cheap float ops land here, the rest go to the FPU
			OP_FLTH, OP_FLTS, OP_FLTD, OP_FLTQ, OP_FLTP:
				case (fn)
					FLT_CMP, FLT_ABS, FLT_NEG:
						isSau = 1'b1;
					default:
						isSau = 1'b0;
				endcase
			// Check and immediate ALU ops
			OP_CHK, OP_ADDI, OP_SUBFI, OP_CMPI, OP_CMPUI:
				isSau = 1'b1;
			OP_ANDI, OP_ORI, OP_XORI:
				isSau = 1'b1;
			// LOADA only forms an address, it never touches memory
			OP_SHIFT, OP_CSR, OP_MOVMR, OP_LOADA:
				isSau = 1'b1;
			// Stack ops adjust the stack pointer here; fence needs no unit
			OP_NOP, OP_PUSH, OP_POP, OP_FENCE:
				isSau = 1'b1;
			default:
				isSau = 1'b0;
		endcase
	endfunction

	assign sau = isSau(instr);

endmodule

`default_nettype wire

/* hw/decodeFpu.sv */
// ==============================
// Classifier for the full floating-point unit. Combinational, no latency
// ==============================

`timescale 1ns/100ps
`default_nettype none

`include "uopDecode_macros.svh"

module decodeFpu
(
	input uopDecodePkg::microOpT instr,
	output logic fpu
);

	import uopDecodePkg::*;

	// Returns one for float ops that need the real FPU datapath
	function automatic logic isFpu(input microOpT ir);
		opcodeT opc;
		funcT fn;
		opc = ir[`OPC_MSB:`OPC_LSB];
		fn = ir[`FUNC_MSB:`FUNC_LSB];
		case (opc)
			OP_FLTH, OP_FLTS, OP_FLTD, OP_FLTQ, OP_FLTP:
				case (fn)
					FLT_ADD, FLT_MUL, FLT_DIV, FLT_SQRT, FLT_CVT:
						isFpu = 1'b1;
					// CMP, ABS and NEG belong to the SAU.
					// Unassigned codes fall through and come out illegal
					default:
						isFpu = 1'b0;
				endcase
			default:
				isFpu = 1'b0;
		endcase
	endfunction

	assign fpu = isFpu(instr);

endmodule

`default_nettype wire

/* hw/decodeMem.sv */
// ==============================
// Classifier for the load/store unit. Combinational, no latency
// ==============================

`timescale 1ns/100ps
`default_nettype none

`include "uopDecode_macros.svh"

module decodeMem
(
	input uopDecodePkg::microOpT instr,
	output logic mem
);

	import uopDecodePkg::*;

	// Returns one for every micro-op that needs the data cache port
	function automatic logic isMem(input microOpT ir);
		opcodeT opc;
		opc = ir[`OPC_MSB:`OPC_LSB];
		case (opc)
			OP_LOAD, OP_STORE:
				isMem = 1'b1;
			// Cache maintenance runs through the same port
			OP_CACHE:
				isMem = 1'b1;
			// LOADA is address arithmetic only and is claimed by the SAU
			default:
				isMem = 1'b0;
		endcase
	endfunction

	// The function field plays no part for memory ops
	assign mem = isMem(instr);

endmodule

`default_nettype wire

/* hw/decodeBranch.sv */
// ==============================
// Classifier for the branch unit. Combinational, no latency
// ==============================

`timescale 1ns/100ps
`default_nettype none

`include "uopDecode_macros.svh"

module decodeBranch
(
	input uopDecodePkg::microOpT instr,
	output logic branch
);

	import uopDecodePkg::*;

	// Returns one for every micro-op that may redirect the fetch stream
	function automatic logic isBranch(input microOpT ir);
		opcodeT opc;
		opc = ir[`OPC_MSB:`OPC_LSB];
		case (opc)
			// Conditional branch, resolved in the branch unit
			OP_BCC:
				isBranch = 1'b1;
			// Unconditional jump and subroutine call
			OP_JMP, OP_JSR:
				isBranch = 1'b1;
			// Return takes its target from the link register
			OP_RET:
				isBranch = 1'b1;
			default:
				isBranch = 1'b0;
		endcase
	endfunction

	assign branch = isBranch(instr);

endmodule

`default_nettype wire

/* hw/uopDecodeStage.sv */
// ==============================
// Micro-op decode stage. Steers one micro-op per clock to a unit type and
// registers it; a high stall holds every output in place
// ==============================

`timescale 1ns/100ps
`default_nettype none

module uopDecodeStage
(
	input logic clk,
	input logic reset,
	input logic stall,
	input logic inValid,
	input uopDecodePkg::microOpT instr,
	output logic outValid,
	output uopDecodePkg::microOpT outInstr,
	output logic sau,
	output logic fpu,
	output logic mem,
	output logic branch,
	output logic illegal
);

	// Raw classifier outputs, not yet qualified by inValid
	logic sauHit;
	logic fpuHit;
	logic memHit;
	logic branchHit;
	// Next-state flags for the output register
	logic sauNext;
	logic fpuNext;
	logic memNext;
	logic branchNext;
	logic illegalNext;

	// ==============================
	// Classifiers
	// ==============================

	decodeSau uSau (.instr(instr), .sau(sauHit));
	decodeFpu uFpu (.instr(instr), .fpu(fpuHit));
	decodeMem uMem (.instr(instr), .mem(memHit));
	decodeBranch uBranch (.instr(instr), .branch(branchHit));

	// An empty slot must not claim a unit
	assign sauNext = inValid & sauHit;
	assign fpuNext = inValid & fpuHit;
	assign memNext = inValid & memHit;
	assign branchNext = inValid & branchHit;
	// Nobody wants it, so it traps further down the pipe.
	// The classifier tables never overlap, so at most one flag is set
	assign illegalNext = inValid & ~(sauHit | fpuHit | memHit | branchHit);

	// ==============================
	// Output register
	// ==============================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
			outInstr <= '0;
			sau <= 1'b0;
			fpu <= 1'b0;
			mem <= 1'b0;
			branch <= 1'b0;
			illegal <= 1'b0;
		end
		else if (!stall)
		begin
			outValid <= inValid;
			// The micro-op moves along even in an empty slot, outValid tells
			outInstr <= instr;
			sau <= sauNext;
			fpu <= fpuNext;
			mem <= memNext;
			branch <= branchNext;
			illegal <= illegalNext;
		end
		// Under stall everything keeps its value, so nothing issues twice
	end

endmodule

`default_nettype wire

/* test/uopDecode_assert.sv */
// ==============================
// Concurrent checks on the decode stage outputs, bound into every
// uopDecodeStage instance. The testbench reads the failure count at the end
// ==============================

`timescale 1ns/100ps
`default_nettype none

module uopDecode_assert
(
	input logic clk,
	input logic reset,
	input logic stall,
	input logic outValid,
	input uopDecodePkg::microOpT outInstr,
	input logic sau,
	input logic fpu,
	input logic mem,
	input logic branch,
	input logic illegal
);

	int unsigned failures = 0;
	logic [4:0] flags;

	assign flags = {sau, fpu, mem, branch, illegal};

	// A micro-op goes to one unit or traps, never both
	flagsOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(flags))
	else
	begin
		failures++;
		$error("More than one unit or illegal flag is high");
	end

	// An empty slot carries no classification
	flagsNeedValid: assert property (@(posedge clk) disable iff (reset) !outValid |-> flags == '0)
	else
	begin
		failures++;
		$error("A flag is high while outValid is low");
	end

	// Stall freezes the whole output register for the following cycle
	stallHolds: assert property (@(posedge clk) disable iff (reset)
		stall |=> $stable({outValid, outInstr, flags}))
	else
	begin
		failures++;
		$error("Outputs changed while stall was high");
	end

endmodule

bind uopDecodeStage uopDecode_assert uAssert
(
	.clk(clk),
	.reset(reset),
	.stall(stall),
	.outValid(outValid),
	.outInstr(outInstr),
	.sau(sau),
	.fpu(fpu),
	.mem(mem),
	.branch(branch),
	.illegal(illegal)
);

`default_nettype wire

/* test/uopDecodeTb.sv */
// ==============================
// Testbench for the decode stage. Runs directed sweeps and a seeded random
// run against a reference model, then prints a one-line summary
// ==============================

`timescale 1ns/100ps
`default_nettype none

`include "uopDecode_macros.svh"

module uopDecodeTb;

	import uopDecodePkg::*;

	// Test lengths in cycles, used for the run limit
	localparam int resetLen = 9;
	localparam int sweepLen = 29 + 5 * 8 + 1;
	localparam int illegalLen = (128 - 34) + 5 * 24 + 1;
	localparam int holdLen = 11;
	localparam int randomLen = 2000 + 1;
	localparam int cycleLimit = resetLen + sweepLen + illegalLen + holdLen + randomLen + 100;

	logic clk;
	logic reset;
	logic stall;
	logic inValid;
	microOpT instr;
	logic outValid;
	microOpT outInstr;
	logic sau;
	logic fpu;
	logic mem;
	logic branch;
	logic illegal;

	// Model register, flags ordered sau, fpu, mem, branch, illegal
	logic mValid;
	microOpT mInstr;
	logic [4:0] mFlags;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic monitorOn = 1'b0;
	logic [31:0] seed = 32'd2030;

	opcodeT assignedOps [0:33] = '{OP_BFLD, OP_R3B, OP_R3W, OP_R3T, OP_R3O, OP_R3P,
		OP_FLTH, OP_FLTS, OP_FLTD, OP_FLTQ, OP_FLTP, OP_CHK, OP_ADDI, OP_SUBFI, OP_CMPI,
		OP_CMPUI, OP_ANDI, OP_ORI, OP_XORI, OP_SHIFT, OP_CSR, OP_MOVMR, OP_LOADA, OP_NOP,
		OP_PUSH, OP_POP, OP_FENCE, OP_LOAD, OP_STORE, OP_CACHE, OP_BCC, OP_JMP, OP_JSR, OP_RET};
	opcodeT fltOps [0:4] = '{OP_FLTH, OP_FLTS, OP_FLTD, OP_FLTQ, OP_FLTP};
	funcT fltFuncs [0:7] = '{FLT_ADD, FLT_MUL, FLT_DIV, FLT_SQRT, FLT_CMP, FLT_ABS,
		FLT_NEG, FLT_CVT};

	uopDecodeStage u_dut
	(
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.inValid(inValid),
		.instr(instr),
		.outValid(outValid),
		.outInstr(outInstr),
		.sau(sau),
		.fpu(fpu),
		.mem(mem),
		.branch(branch),
		.illegal(illegal)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==============================
	// Random source and reference model
	// ==============================

	// Upper half of the LCG state, the low bits cycle too quickly
	function logic [15:0] lcgStep();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	function automatic microOpT makeUop(input opcodeT opc, input funcT fn);
		microOpT u;
		u = {lcgStep(), lcgStep()};
		u[`OPC_MSB:`OPC_LSB] = opc;
		u[`FUNC_MSB:`FUNC_LSB] = fn;
		return u;
	endfunction

	// Half take an assigned opcode, and half of those an assigned function too
	function automatic microOpT randomUop();
		microOpT u;
		u = {lcgStep(), lcgStep()};
		if (lcgStep() % 2 == 0)
		begin
			u[`OPC_MSB:`OPC_LSB] = assignedOps[lcgStep() % 34];
			if (lcgStep() % 2 == 0)
				u[`FUNC_MSB:`FUNC_LSB] = fltFuncs[lcgStep() % 8];
		end
		return u;
	endfunction

	// Unit table for a valid micro-op, as one-hot sau, fpu, mem, branch, illegal
	function automatic logic [4:0] expectedFlags(input microOpT u);
		opcodeT opc;
		funcT fn;
		logic isFlt;
		opc = u[`OPC_MSB:`OPC_LSB];
		fn = u[`FUNC_MSB:`FUNC_LSB];
		isFlt = opc inside {OP_FLTH, OP_FLTS, OP_FLTD, OP_FLTQ, OP_FLTP};
		if (isFlt && (fn inside {FLT_CMP, FLT_ABS, FLT_NEG}))
			return 5'b10000;
		if (isFlt && (fn inside {FLT_ADD, FLT_MUL, FLT_DIV, FLT_SQRT, FLT_CVT}))
			return 5'b01000;
		if (opc inside {OP_BFLD, OP_R3B, OP_R3W, OP_R3T, OP_R3O, OP_R3P, OP_CHK, OP_ADDI,
			OP_SUBFI, OP_CMPI, OP_CMPUI, OP_ANDI, OP_ORI, OP_XORI, OP_SHIFT, OP_CSR,
			OP_MOVMR, OP_LOADA, OP_NOP, OP_PUSH, OP_POP, OP_FENCE})
			return 5'b10000;
		if (opc inside {OP_LOAD, OP_STORE, OP_CACHE})
			return 5'b00100;
		if (opc inside {OP_BCC, OP_JMP, OP_JSR, OP_RET})
			return 5'b00010;
		return 5'b00001;
	endfunction

	// One-cycle register with hold, mirrors the stage timing
	always @(posedge clk)
	begin
		if (reset)
		begin
			mValid <= 1'b0;
			mInstr <= '0;
			mFlags <= '0;
		end
		else if (!stall)
		begin
			mValid <= inValid;
			mInstr <= instr;
			mFlags <= inValid ? expectedFlags(instr) : 5'b0;
		end
	end

	// ==============================
	// Compare tasks and drivers
	// ==============================

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: flag %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkUop(input microOpT got, input microOpT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: outInstr is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic checkValid(input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: outValid is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic checkAllFlags(input logic [4:0] exp);
		checkFlag("sau", sau, exp[4]);
		checkFlag("fpu", fpu, exp[3]);
		checkFlag("mem", mem, exp[2]);
		checkFlag("branch", branch, exp[1]);
		checkFlag("illegal", illegal, exp[0]);
	endtask

	task automatic expectIdle();
		checkValid(outValid, 1'b0);
		checkUop(outInstr, '0);
		checkAllFlags(5'b0);
	endtask

	task automatic drive(input logic v, input logic s, input microOpT u);
		@(posedge clk);
		inValid <= v;
		stall <= s;
		instr <= u;
	endtask

	// Back to back, each result is checked while the next micro-op goes in
	task automatic runDirected(input microOpT q[$]);
		for (int i = 0; i <= q.size(); i++)
		begin
			if (i < q.size())
				drive(1'b1, 1'b0, q[i]);
			else
				drive(1'b0, 1'b0, '0);
			@(negedge clk);
			if (i > 0)
			begin
				checkValid(outValid, 1'b1);
				checkUop(outInstr, q[i-1]);
				checkAllFlags(expectedFlags(q[i-1]));
			end
		end
	endtask

	task automatic reportTest(input string name, input int mark);
		$display("%s: %s, %0d errors", name, (errors == mark) ? "ok" : "failed", errors - mark);
	endtask

	// Checks every output against the model in mid cycle once reset is done
	always @(negedge clk)
	begin
		if (monitorOn)
		begin
			checkValid(outValid, mValid);
			checkUop(outInstr, mInstr);
			checkAllFlags(mFlags);
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ==============================
	// Test sequence
	// ==============================

	initial
	begin
		microOpT q[$];
		microOpT uA;
		microOpT uB;
		int mark;
		reset = 1'b1;
		stall = 1'b0;
		inValid = 1'b0;
		instr = '0;

		// Eight reset edges with live input, then one idle cycle
		mark = errors;
		for (int i = 0; i < 8; i++)
		begin
			@(posedge clk);
			reset <= (i < 7);
			inValid <= (i < 7);
			stall <= 1'b0;
			instr <= (i < 7) ? randomUop() : '0;
			@(negedge clk);
			expectIdle();
		end
		drive(1'b0, 1'b0, '0);
		monitorOn = 1'b1;
		@(negedge clk);
		expectIdle();
		reportTest("reset", mark);

		// Every assigned opcode, FLT opcodes crossed with every function
		mark = errors;
		foreach (assignedOps[k])
		begin
			if (assignedOps[k] inside {OP_FLTH, OP_FLTS, OP_FLTD, OP_FLTQ, OP_FLTP})
			begin
				foreach (fltFuncs[f])
					q.push_back(makeUop(assignedOps[k], fltFuncs[f]));
			end
			else
				q.push_back(makeUop(assignedOps[k], funcT'(lcgStep())));
		end
		runDirected(q);
		reportTest("directed sweep", mark);

		// Unassigned opcodes, then FLT opcodes with unassigned functions
		mark = errors;
		q.delete();
		for (int o = 0; o < 128; o++)
		begin
			if (expectedFlags(makeUop(opcodeT'(o), FLT_ADD)) == 5'b00001)
				q.push_back(makeUop(opcodeT'(o), funcT'(lcgStep())));
		end
		foreach (fltOps[k])
		begin
			for (int f = 8; f < 32; f++)
				q.push_back(makeUop(fltOps[k], funcT'(f)));
		end
		runDirected(q);
		reportTest("illegal", mark);

		// Empty slots, then A held three cycles under stall while an empty B slot waits
		mark = errors;
		repeat (4)
		begin
			drive(1'b0, 1'b0, randomUop());
			@(negedge clk);
			checkValid(outValid, 1'b0);
			checkAllFlags(5'b0);
		end
		uA = makeUop(OP_ADDI, funcT'(lcgStep()));
		uB = makeUop(OP_BCC, funcT'(lcgStep()));
		drive(1'b1, 1'b0, uA);
		for (int i = 0; i < 4; i++)
		begin
			drive((i == 3), (i < 3), uB);
			@(negedge clk);
			checkValid(outValid, 1'b1);
			checkUop(outInstr, uA);
			checkAllFlags(expectedFlags(uA));
		end
		// After release B must follow at once, and only once
		drive(1'b0, 1'b0, randomUop());
		@(negedge clk);
		checkValid(outValid, 1'b1);
		checkUop(outInstr, uB);
		checkAllFlags(expectedFlags(uB));
		drive(1'b0, 1'b0, randomUop());
		@(negedge clk);
		checkValid(outValid, 1'b0);
		checkAllFlags(5'b0);
		reportTest("invalid and stall", mark);

		// Long random run, checked by the model monitor
		mark = errors;
		repeat (2000)
			drive(lcgStep() % 10 < 8, lcgStep() % 10 < 2, randomUop());
		drive(1'b0, 1'b0, '0);
		@(negedge clk);
		reportTest("random", mark);

		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			u_dut.uAssert.failures);
		if (errors == 0 && u_dut.uAssert.failures == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
hw/uopDecodePkg.sv
hw/decodeSau.sv
hw/decodeFpu.sv
hw/decodeMem.sv
hw/decodeBranch.sv
hw/uopDecodeStage.sv
test/uopDecode_assert.sv
test/uopDecodeTb.sv
